//--- rtl/dragon_pkg.sv
/*
 * Dragon chase game shared definitions
 * Grid cell word with its two views, heading codes, score type
 * and the start cells of player and dragon
 */
`default_nettype none

package dragon_pkg;

    // One cell on the 16 x 16 grid, x in the upper nibble
    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } grid_xy_t;

    // Same byte seen as coordinates or as one raw word for compares
    typedef union packed {
        grid_xy_t   xy;   // Chase rule and clamping
        logic [7:0] raw;  // Collision compare and body chain
    } grid_pos_t;

    // Heading codes, y growing downward
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_DOWN  = 2'd2,
        DIR_LEFT  = 2'd3
    } dir_t;

    typedef logic [15:0] score_t;  // Frames survived

    // Opposite corners so the game does not start in a catch
    localparam grid_pos_t PLAYER_START = 8'hff;  // x=15, y=15
    localparam grid_pos_t DRAGON_START = 8'h00;  // x=0, y=0

endpackage

`default_nettype wire

//--- rtl/player_mover.sv
/*
 * Player token mover
 * Takes one move request per frame over valid/ready and steps the
 * player one cell, holding each coordinate at the grid edge
 */
`default_nettype none

module player_mover (
    input  wire                   vsync,
    input  wire                   reset,
    input  wire                   move_valid,
    input  dragon_pkg::dir_t      move_dir,
    input  wire                   game_over,
    output logic                  move_ready,
    output dragon_pkg::grid_pos_t player_pos
);
    import dragon_pkg::*;

    logic move_take;  // Handshake completes this frame

    // Requests stall once the game has ended
    assign move_ready = ~game_over;
    assign move_take  = move_valid & move_ready;

    always_ff @(posedge vsync) begin
        if (!reset) begin
            player_pos <= PLAYER_START;
        end else if (move_take) begin
            case (move_dir)
                DIR_UP: begin
                    if (player_pos.xy.y != 4'd0)
                        player_pos.xy.y <= player_pos.xy.y - 4'd1;
                end
                DIR_RIGHT: begin
                    if (player_pos.xy.x != 4'd15)
                        player_pos.xy.x <= player_pos.xy.x + 4'd1;
                end
                DIR_DOWN: begin
                    if (player_pos.xy.y != 4'd15)
                        player_pos.xy.y <= player_pos.xy.y + 4'd1;
                end
                default: begin  // DIR_LEFT
                    if (player_pos.xy.x != 4'd0)
                        player_pos.xy.x <= player_pos.xy.x - 4'd1;
                end
            endcase
        end
    end

    // Token only moves on an accepted request
    a_pos_hold: assert property (@(posedge vsync) disable iff (!reset)
        !move_take |=> $stable(player_pos.raw));

endmodule

`default_nettype wire

//--- rtl/dragon_head.sv
/*
 * Dragon head chaser
 * Frame divider plus one-cell chase step toward the player.
 * Reports heading, a one-frame step pulse and the cell just left
 */
`default_nettype none

module dragon_head #(
    parameter int MOVE_PERIOD = 10  // Frames between steps, minus one
) (
    input  wire                   vsync,
    input  wire                   reset,
    input  dragon_pkg::grid_pos_t player_pos,
    input  wire                   game_over,
    output dragon_pkg::grid_pos_t head_pos,
    output dragon_pkg::dir_t      head_dir,
    output logic                  step,
    output dragon_pkg::grid_pos_t prev_pos
);
    import dragon_pkg::*;

    localparam int CNT_W = (MOVE_PERIOD > 0) ? $clog2(MOVE_PERIOD + 1) : 1;

    logic [CNT_W-1:0] frame_cnt;  // Divider, 0 .. MOVE_PERIOD
    logic             wrap;       // Divider at its last count
    logic             moving;     // Head is off the player cell
    logic             head_step;  // Head takes a step at this edge
    logic             x_less;     // Player lies right of the head
    logic             y_less;     // Player lies below the head
    logic [3:0]       dx;
    logic [3:0]       dy;
    grid_pos_t        next_pos;
    dir_t             next_dir;

    assign wrap      = (frame_cnt == CNT_W'(MOVE_PERIOD));
    assign moving    = (head_pos.raw != player_pos.raw);
    assign head_step = wrap & moving & ~game_over;

    // Sign and magnitude per axis
    assign x_less = (head_pos.xy.x < player_pos.xy.x);
    assign y_less = (head_pos.xy.y < player_pos.xy.y);
    assign dx     = x_less ? player_pos.xy.x - head_pos.xy.x
                           : head_pos.xy.x - player_pos.xy.x;
    assign dy     = y_less ? player_pos.xy.y - head_pos.xy.y
                           : head_pos.xy.y - player_pos.xy.y;

    // One axis per step, x wins a tie
    always_comb begin
        next_pos = head_pos;
        next_dir = head_dir;
        if (dx >= dy) begin
            if (x_less) begin
                next_pos.xy.x = head_pos.xy.x + 4'd1;
                next_dir      = DIR_RIGHT;
            end else begin
                next_pos.xy.x = head_pos.xy.x - 4'd1;
                next_dir      = DIR_LEFT;
            end
        end else if (y_less) begin
            next_pos.xy.y = head_pos.xy.y + 4'd1;  // Down the screen
            next_dir      = DIR_DOWN;
        end else begin
            next_pos.xy.y = head_pos.xy.y - 4'd1;
            next_dir      = DIR_UP;
        end
    end

    always_ff @(posedge vsync) begin
        if (!reset) begin
            frame_cnt <= '0;
            head_pos  <= DRAGON_START;
            head_dir  <= DIR_UP;
            step      <= 1'b0;
        end else if (game_over) begin
            step <= 1'b0;  // Divider and position frozen
        end else begin
            step <= head_step;
            if (wrap) begin
                frame_cnt <= '0;
                if (moving) begin
                    head_pos <= next_pos;
                    head_dir <= next_dir;
                end
            end else begin
                frame_cnt <= frame_cnt + CNT_W'(1);
            end
        end
    end

    // Former cell, valid while step is high
    always_ff @(posedge vsync) begin
        if (head_step)
            prev_pos <= head_pos;
    end

    // Exactly one coordinate changed on a step
    a_one_axis: assert property (@(posedge vsync) disable iff (!reset)
        step |-> ((head_pos.xy.x == prev_pos.xy.x) != (head_pos.xy.y == prev_pos.xy.y)));

    a_frozen: assert property (@(posedge vsync) disable iff (!reset)
        game_over |=> $stable(head_pos.raw));

endmodule

`default_nettype wire

//--- rtl/dragon_body.sv
/*
 * Dragon body chain
 * BODY_LEN cell registers shifted on each head step, so the body
 * replays the path the head has taken
 */
`default_nettype none

module dragon_body #(
    parameter int BODY_LEN = 4  // Number of segments
) (
    input  wire                   vsync,
    input  wire                   reset,
    input  wire                   step,
    input  dragon_pkg::grid_pos_t prev_pos,
    output dragon_pkg::grid_pos_t body_pos [BODY_LEN]
);
    import dragon_pkg::*;

    // Segment 0 sits right behind the head
    always_ff @(posedge vsync) begin
        if (!reset) begin
            for (int k = 0; k < BODY_LEN; k++) begin
                body_pos[k] <= DRAGON_START;  // Coiled on the head at start
            end
        end else if (step) begin
            body_pos[0] <= prev_pos;
            for (int k = 1; k < BODY_LEN; k++) begin
                body_pos[k] <= body_pos[k-1];  // Raw byte moves down the chain
            end
        end
    end

    // Each segment holds between steps
    for (genvar k = 0; k < BODY_LEN; k++) begin : g_seg_chk
        a_seg_hold: assert property (@(posedge vsync) disable iff (!reset)
            !step |=> $stable(body_pos[k].raw));
    end

endmodule

`default_nettype wire

//--- rtl/hit_detector.sv
/*
 * Collision and score
 * Raw compare of the player cell against head and body, a sticky
 * game over flag and a saturating count of frames survived
 */
`default_nettype none

module hit_detector #(
    parameter int BODY_LEN = 4
) (
    input  wire                   vsync,
    input  wire                   reset,
    input  dragon_pkg::grid_pos_t player_pos,
    input  dragon_pkg::grid_pos_t head_pos,
    input  dragon_pkg::grid_pos_t body_pos [BODY_LEN],
    output logic                  game_over,
    output dragon_pkg::score_t    score
);
    import dragon_pkg::*;

    logic hit;  // Player shares a cell with the dragon

    always_comb begin
        hit = (player_pos.raw == head_pos.raw);
        for (int k = 0; k < BODY_LEN; k++) begin
            if (player_pos.raw == body_pos[k].raw)
                hit = 1'b1;
        end
    end

    always_ff @(posedge vsync) begin
        if (!reset) begin
            game_over <= 1'b0;
            score     <= '0;
        end else begin
            if (hit)
                game_over <= 1'b1;  // Sticky until reset
            if (!game_over && score != '1)
                score <= score + score_t'(1);
        end
    end

    // Only reset clears the flag
    a_over_sticky: assert property (@(posedge vsync)
        game_over && reset |=> game_over);

endmodule

`default_nettype wire

//--- rtl/dragon_game_top.sv
/*
 * Dragon chase game top
 * Player mover, dragon head, body chain and hit detector, all on
 * vsync so one cycle is one frame
 */
`default_nettype none

module dragon_game_top #(
    parameter int MOVE_PERIOD = 10,  // Head steps every MOVE_PERIOD+1 frames
    parameter int BODY_LEN    = 4
) (
    input  wire                   vsync,
    input  wire                   reset,
    input  wire                   move_valid,
    input  dragon_pkg::dir_t      move_dir,
    output logic                  move_ready,
    output dragon_pkg::grid_pos_t player_pos,
    output dragon_pkg::grid_pos_t head_pos,
    output dragon_pkg::dir_t      head_dir,
    output dragon_pkg::grid_pos_t body_pos [BODY_LEN],
    output logic                  game_over,
    output dragon_pkg::score_t    score
);
    import dragon_pkg::*;

    logic      step;      // Head moved last frame
    grid_pos_t prev_pos;  // Cell the head left

    player_mover u_player (
        .vsync      (vsync),
        .reset      (reset),
        .move_valid (move_valid),
        .move_dir   (move_dir),
        .game_over  (game_over),
        .move_ready (move_ready),
        .player_pos (player_pos)
    );

    dragon_head #(
        .MOVE_PERIOD (MOVE_PERIOD)
    ) u_head (
        .vsync      (vsync),
        .reset      (reset),
        .player_pos (player_pos),
        .game_over  (game_over),
        .head_pos   (head_pos),
        .head_dir   (head_dir),
        .step       (step),
        .prev_pos   (prev_pos)
    );

    dragon_body #(
        .BODY_LEN (BODY_LEN)
    ) u_body (
        .vsync    (vsync),
        .reset    (reset),
        .step     (step),
        .prev_pos (prev_pos),
        .body_pos (body_pos)
    );

    hit_detector #(
        .BODY_LEN (BODY_LEN)
    ) u_hit (
        .vsync      (vsync),
        .reset      (reset),
        .player_pos (player_pos),
        .head_pos   (head_pos),
        .body_pos   (body_pos),
        .game_over  (game_over),
        .score      (score)
    );

endmodule

`default_nettype wire

//--- dv/dragon_ref.svh
/*
 * Reference model of the dragon chase game
 * Next player cell, next head cell with its heading, body chain shift
 * and the catch test, all worked out from the game rules
 */
`ifndef DRAGON_REF_SVH
`define DRAGON_REF_SVH

// One cell per accepted request, clamped to 0..15 on both axes
function automatic grid_pos_t next_player(grid_pos_t pos, logic take, dir_t dir);
    int        x;
    int        y;
    grid_pos_t n;
    x = int'(pos.xy.x);
    y = int'(pos.xy.y);
    if (take) begin
        case (dir)
            DIR_UP:    y = y - 1;
            DIR_DOWN:  y = y + 1;  // y grows downward
            DIR_LEFT:  x = x - 1;
            default:   x = x + 1;
        endcase
    end
    if (x < 0) x = 0;
    if (x > 15) x = 15;
    if (y < 0) y = 0;
    if (y > 15) y = 15;
    n.xy.x = 4'(x);
    n.xy.y = 4'(y);
    return n;
endfunction

// Chase step, only called when head and player differ
function automatic grid_pos_t next_head(input grid_pos_t head, input grid_pos_t player,
                                        output dir_t dir);
    int        dx;
    int        dy;
    grid_pos_t n;
    dx = int'(player.xy.x) - int'(head.xy.x);  // Signed offsets
    dy = int'(player.xy.y) - int'(head.xy.y);
    n  = head;
    if ((dx < 0 ? -dx : dx) >= (dy < 0 ? -dy : dy)) begin  // Tie goes to x
        n.xy.x = (dx > 0) ? head.xy.x + 4'd1 : head.xy.x - 4'd1;
        dir    = (dx > 0) ? DIR_RIGHT : DIR_LEFT;
    end else begin
        n.xy.y = (dy > 0) ? head.xy.y + 4'd1 : head.xy.y - 4'd1;
        dir    = (dy > 0) ? DIR_DOWN : DIR_UP;
    end
    return n;
endfunction

// Former head cell enters at segment 0, the rest move one down
function automatic chain_t next_body(chain_t chain, grid_pos_t prev);
    chain_t n;
    n[0] = prev;
    for (int k = 1; k < BODY_LEN; k++)
        n[k] = chain[k-1];
    return n;
endfunction

function automatic logic catches(grid_pos_t player, grid_pos_t head, chain_t chain);
    logic hit;
    hit = (player.raw == head.raw);
    for (int k = 0; k < BODY_LEN; k++)
        if (player.raw == chain[k].raw) hit = 1'b1;
    return hit;
endfunction

`endif

//--- dv/dragon_game_tb.sv
/*
 * Dragon chase game testbench
 * Directed and random player moves, a frame-by-frame model of the
 * whole game and a compare process on the falling edge
 */
`default_nettype none

module dragon_game_tb;
    import dragon_pkg::*;

    localparam int MOVE_PERIOD = 3;
    localparam int BODY_LEN    = 4;
    localparam int WAIT_FRAMES = 200;  // Limit for every wait loop

    typedef grid_pos_t [BODY_LEN-1:0] chain_t;  // Model body, segment 0 first

    `include "dragon_ref.svh"

    logic      vsync;
    logic      reset;
    logic      move_valid;
    dir_t      move_dir;
    logic      move_ready;
    grid_pos_t player_pos;
    grid_pos_t head_pos;
    dir_t      head_dir;
    grid_pos_t body_pos [BODY_LEN];
    logic      game_over;
    score_t    score;

    // Model state, advanced at each rising edge
    grid_pos_t m_player;
    grid_pos_t m_head;
    grid_pos_t m_prev;
    dir_t      m_dir;
    chain_t    m_body;
    int        m_cnt;
    logic      m_step;
    logic      m_over;
    logic      m_hit;
    score_t    m_score;
    logic      model_ready = 1'b0;  // Set by the first reset edge

    int    seed;
    string test_name;
    int    test_errors;
    int    n_checks;
    int    n_errors;
    int    n_tests;
    int    n_failed;

    dragon_game_top #(
        .MOVE_PERIOD (MOVE_PERIOD),
        .BODY_LEN    (BODY_LEN)
    ) uut (
        .vsync      (vsync),
        .reset      (reset),
        .move_valid (move_valid),
        .move_dir   (move_dir),
        .move_ready (move_ready),
        .player_pos (player_pos),
        .head_pos   (head_pos),
        .head_dir   (head_dir),
        .body_pos   (body_pos),
        .game_over  (game_over),
        .score      (score)
    );

    initial begin
        vsync = 1'b0;
        forever #2 vsync = ~vsync;  // One frame every 4 units
    end

    task automatic check_pos(input string what, input grid_pos_t exp, input grid_pos_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp.raw, act.raw);
        end
    endtask

    task automatic check_dir(input string what, input dir_t exp, input dir_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errors++;
            $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_score(input string what, input score_t exp, input score_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            test_errors++;
            $display("** Error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // Model update, inputs read here still hold their pre-edge values
    always @(posedge vsync) begin
        if (!reset) begin
            m_player = PLAYER_START;
            m_head   = DRAGON_START;
            m_prev   = DRAGON_START;
            m_dir    = DIR_UP;
            m_cnt    = 0;
            m_step   = 1'b0;
            m_over   = 1'b0;
            m_score  = '0;
            for (int k = 0; k < BODY_LEN; k++)
                m_body[k] = DRAGON_START;  // Coiled under the head
            model_ready = 1'b1;
        end else begin
            m_hit = catches(m_player, m_head, m_body);  // Old cells decide the catch
            if (!m_over && m_score != '1)
                m_score = m_score + 16'd1;
            if (m_step)
                m_body = next_body(m_body, m_prev);  // One frame behind the head
            if (m_over) begin
                m_step = 1'b0;  // Everything frozen
            end else if (m_cnt == MOVE_PERIOD) begin
                m_cnt  = 0;
                m_step = (m_head.raw != m_player.raw);
                if (m_step) begin
                    m_prev = m_head;
                    m_head = next_head(m_head, m_player, m_dir);
                end
            end else begin
                m_cnt++;
                m_step = 1'b0;
            end
            m_player = next_player(m_player, move_valid && !m_over, move_dir);
            m_over   = m_over | m_hit;
        end
    end

    // Compare every frame where outputs are settled
    initial begin
        forever begin
            @(negedge vsync);
            if (model_ready) begin
                check_pos("player_pos", m_player, player_pos);
                check_pos("head_pos", m_head, head_pos);
                check_dir("head_dir", m_dir, head_dir);
                for (int k = 0; k < BODY_LEN; k++)
                    check_pos($sformatf("body_pos[%0d]", k), m_body[k], body_pos[k]);
                check_flag("game_over", m_over, game_over);
                check_flag("move_ready", !m_over, move_ready);
                check_score("score", m_score, score);
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        n_tests++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            n_failed++;
            $display("FAIL %s, %0d errors", test_name, test_errors);
        end
    endtask

    task automatic apply_reset();
        @(posedge vsync);
        reset      <= 1'b0;
        move_valid <= 1'b0;
        repeat (3) @(posedge vsync);  // Three frames in reset
        reset <= 1'b1;
    endtask

    // Each request waits for ready, one idle frame between requests
    task automatic send_move(input dir_t dir, input int count);
        int   tries;
        logic rdy;
        for (int i = 0; i < count; i++) begin
            @(posedge vsync);
            move_valid <= 1'b1;
            move_dir   <= dir;
            tries = 0;
            rdy   = 1'b0;
            while (!rdy && tries < WAIT_FRAMES) begin
                @(negedge vsync);
                rdy = move_ready;
                @(posedge vsync);  // Accepted here when rdy was high
                tries++;
            end
            move_valid <= 1'b0;
            if (!rdy) begin
                n_errors++;
                test_errors++;
                $display("Timeout in %s: a move request was never accepted", test_name);
            end
        end
    endtask

    task automatic expect_player(input int x, input int y);
        grid_pos_t exp;
        exp.xy.x = 4'(x);
        exp.xy.y = 4'(y);
        @(negedge vsync);
        check_pos("final player cell", exp, player_pos);
    endtask

    // Random directions and gaps, stops driving once the game ends
    task automatic random_moves(input int frames);
        logic [31:0] rnd;
        logic        stop;
        stop = 1'b0;
        for (int i = 0; i < frames && !stop; i++) begin
            @(posedge vsync);
            rnd = $random(seed);
            move_valid <= (rnd[3:2] != 2'b00);  // About one frame in four idle
            move_dir   <= dir_t'(rnd[1:0]);
            @(negedge vsync);
            stop = game_over;  // Pending request then holds steady
        end
    endtask

    function automatic dir_t steer_dir(grid_pos_t from, grid_pos_t to);
        if (from.xy.x < to.xy.x) return DIR_RIGHT;
        if (from.xy.x > to.xy.x) return DIR_LEFT;
        if (from.xy.y < to.xy.y) return DIR_DOWN;
        return DIR_UP;
    endfunction

    // Walk the player into the head, then watch the frozen game
    task automatic catch_and_hold();
        int        frames;
        logic      over;
        dir_t      d;
        grid_pos_t held_head;
        chain_t    held_body;
        score_t    held_score;
        frames = 0;
        over   = 1'b0;
        while (!over && frames < WAIT_FRAMES) begin
            @(negedge vsync);
            over = game_over;
            d    = steer_dir(player_pos, head_pos);
            @(posedge vsync);
            if (!over) begin
                move_valid <= 1'b1;
                move_dir   <= d;
            end
            frames++;
        end
        if (!over) begin
            n_errors++;
            test_errors++;
            $display("Timeout in %s: the game never ended within %0d frames",
                     test_name, WAIT_FRAMES);
        end else begin
            @(negedge vsync);
            check_flag("move_ready after catch", 1'b0, move_ready);
            held_head  = m_head;
            held_body  = m_body;
            held_score = m_score;
            repeat (20) @(posedge vsync);  // Request left waiting
            @(negedge vsync);
            check_pos("frozen head", held_head, head_pos);
            for (int k = 0; k < BODY_LEN; k++)
                check_pos($sformatf("frozen body[%0d]", k), held_body[k], body_pos[k]);
            check_score("frozen score", held_score, score);
            check_flag("game_over held", 1'b1, game_over);
        end
    endtask

    initial begin
        seed        = 32'h89e725ab;
        reset       = 1'b0;
        move_valid  = 1'b0;
        move_dir    = DIR_UP;
        test_name   = "";
        test_errors = 0;
        n_checks    = 0;
        n_errors    = 0;
        n_tests     = 0;
        n_failed    = 0;

        start_test("reset_state");
        repeat (2) @(posedge vsync);
        @(negedge vsync);
        check_pos("reset player", PLAYER_START, player_pos);
        check_pos("reset head", DRAGON_START, head_pos);
        for (int k = 0; k < BODY_LEN; k++)
            check_pos($sformatf("reset body[%0d]", k), DRAGON_START, body_pos[k]);
        check_dir("reset head_dir", DIR_UP, head_dir);
        check_flag("reset game_over", 1'b0, game_over);
        check_flag("reset move_ready", 1'b1, move_ready);
        check_score("reset score", '0, score);
        @(posedge vsync);
        reset <= 1'b1;  // Third reset frame ends here
        finish_test();

        start_test("player_edges");
        send_move(DIR_RIGHT, 3);  // Already on x=15
        send_move(DIR_DOWN, 3);   // Already on y=15
        repeat (4) @(posedge vsync);
        send_move(DIR_UP, 18);
        expect_player(15, 0);
        finish_test();

        start_test("player_left");
        apply_reset();
        send_move(DIR_LEFT, 18);
        send_move(DIR_DOWN, 2);
        expect_player(0, 15);
        finish_test();

        start_test("random_chase");
        apply_reset();
        random_moves(160);
        finish_test();

        start_test("catch_and_freeze");
        apply_reset();
        catch_and_hold();
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+dv
rtl/dragon_pkg.sv
rtl/player_mover.sv
rtl/dragon_head.sv
rtl/dragon_body.sv
rtl/hit_detector.sv
rtl/dragon_game_top.sv
dv/dragon_game_tb.sv

//--- Makefile
# Dragon chase game, Verilator flow

.PHONY: all lint sim clean

all: sim

# Lint the RTL files of the file list
lint:
	verilator --lint-only -Wall --top-module dragon_game_top $(shell grep '^rtl/' compile.f)

# Build and run the testbench, the log decides pass or fail
sim:
	verilator --binary --timing --assert -f compile.f --top-module dragon_game_tb \
		-Mdir obj_dir -o dragon_sim
	-./obj_dir/dragon_sim > sim.log 2>&1
	@cat sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
